/* dv/ent_ht_tb.sv */
`timescale 1ns/1ps
`include "ent_ht_params.svh"

module ent_ht_tb;
  import ent_ht_pkg::*;

  localparam int TimeoutCycles = 200;
  // STATUS field positions
  localparam int FailLsb = 16;
  localparam int ErrBit  = 24;
  localparam int FailBit = 25;

  logic     clk_i = 1'b0;
  logic     reset_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_addr_t wb_adr_i;
  wb_data_t wb_dat_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;
  symbol_t  rng_symbol_i;
  logic     rng_valid_i;
  logic     alert_o;
  logic     count_err_o;

  // Reference histogram of the current window
  int       hist [`ENT_NUM_BINS];
  integer   seed;
  int       errors;
  int       timeouts;
  int       alert_pulses = 0;
  int       monitor_errors = 0;
  logic     count_err_seen = 1'b0;
  wb_data_t rd;
  cnt_t     last_max;

  ent_ht_top u_ent_ht_top (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .rng_symbol_i (rng_symbol_i),
    .rng_valid_i  (rng_valid_i),
    .alert_o      (alert_o),
    .count_err_o  (count_err_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  // Alert is a one-cycle pulse, so one high sample per pulse
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (alert_o) begin
        alert_pulses = alert_pulses + 1;
      end
      if (count_err_o && !count_err_seen) begin
        $display("FAILED count_err_o: got 0x%h expected 0x0 at %0t", count_err_o, $time);
        count_err_seen = 1'b1;
        monitor_errors = monitor_errors + 1;
      end
    end
  end

  task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      errors = errors + 1;
    end
  endtask

  // One classic cycle, stb dropped after ack
  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           output wb_data_t rdat);
    int n;
    n = 0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    @(negedge clk_i);
    while (!wb_ack_o && n < TimeoutCycles) begin
      @(negedge clk_i);
      n = n + 1;
    end
    if (!wb_ack_o) begin
      $display("No ack from the slave for address 0x%h", adr);
      timeouts = timeouts + 1;
    end
    rdat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic clear_hist();
    foreach (hist[i]) begin
      hist[i] = 0;
    end
  endtask

  function automatic cnt_t hist_max();
    int m;
    m = 0;
    foreach (hist[i]) begin
      if (hist[i] > m) m = hist[i];
    end
    return cnt_t'(m);
  endfunction

  // Back-to-back symbols, valid dropped by drive_idle
  task automatic drive_symbol(input symbol_t sym);
    @(posedge clk_i);
    rng_symbol_i <= sym;
    rng_valid_i  <= 1'b1;
    hist[sym] = hist[sym] + 1;
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    rng_valid_i <= 1'b0;
  endtask

  task automatic send_random(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      drive_symbol(symbol_t'($random(seed)));
    end
    drive_idle();
  endtask

  // 20 copies of one value and 4 distinct others, a 24-symbol window
  task automatic send_fail_window(input symbol_t sym);
    int i;
    for (i = 0; i < 20; i++) begin
      drive_symbol(sym);
    end
    for (i = 1; i <= 4; i++) begin
      drive_symbol(symbol_t'(sym + symbol_t'(i)));
    end
    drive_idle();
  endtask

  task automatic wait_alert();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!alert_o && n < TimeoutCycles) begin
      @(negedge clk_i);
      n = n + 1;
    end
    if (!alert_o) begin
      $display("alert_o did not pulse after a failing window");
      timeouts = timeouts + 1;
    end
  endtask

  task automatic test_reset_values();
    wb_read(`ENT_REG_CTRL, rd);
    check_data("CTRL", rd, 32'h0);
    wb_read(`ENT_REG_THRESH, rd);
    check_data("THRESH", rd, 32'h0);
    wb_read(`ENT_REG_WINDOW, rd);
    check_data("WINDOW", rd, 32'd64);
    wb_read(`ENT_REG_STATUS, rd);
    check_data("STATUS", rd, 32'h0);
    wb_write(`ENT_REG_THRESH, 32'h0000_1234);
    wb_read(`ENT_REG_THRESH, rd);
    check_data("THRESH", rd, 32'h0000_1234);
    wb_write(`ENT_REG_WINDOW, 32'h0000_0020);
    wb_read(`ENT_REG_WINDOW, rd);
    check_data("WINDOW", rd, 32'h0000_0020);
    // Clear bit reads back as zero
    wb_write(`ENT_REG_CTRL, 32'h3);
    wb_read(`ENT_REG_CTRL, rd);
    check_data("CTRL", rd, 32'h1);
  endtask

  task automatic test_random_windows();
    int start_alerts;
    cnt_t exp_max;
    wb_write(`ENT_REG_THRESH, 32'h0000_FFFF);
    wb_write(`ENT_REG_WINDOW, 32'd32);
    wb_write(`ENT_REG_CTRL, 32'h3);
    start_alerts = alert_pulses;
    repeat (4) begin
      clear_hist();
      send_random(32);
      exp_max = hist_max();
      wb_read(`ENT_REG_STATUS, rd);
      check_cnt("STATUS.max", rd[15:0], exp_max);
      check_cnt("STATUS.fail_cnt", cnt_t'(rd[FailLsb +: 8]), '0);
      check_bit("STATUS.count_err", rd[ErrBit], 1'b0);
    end
    check_cnt("alert_o pulses", cnt_t'(alert_pulses - start_alerts), '0);
  endtask

  task automatic test_single_symbol_fail();
    int start_alerts;
    cnt_t exp_max;
    wb_write(`ENT_REG_WINDOW, 32'd24);
    wb_write(`ENT_REG_THRESH, 32'd10);
    wb_write(`ENT_REG_CTRL, 32'h3);
    start_alerts = alert_pulses;
    clear_hist();
    send_fail_window(symbol_t'($random(seed)));
    wait_alert();
    exp_max = hist_max();
    wb_read(`ENT_REG_STATUS, rd);
    check_cnt("STATUS.fail_cnt", cnt_t'(rd[FailLsb +: 8]), (exp_max > 10) ? 16'd1 : 16'd0);
    check_bit("STATUS.fail", rd[FailBit], 1'b1);
    check_cnt("STATUS.max", rd[15:0], exp_max);
    check_bit("STATUS.max at least 20", rd[15:0] >= 16'd20, 1'b1);
    check_cnt("alert_o pulses", cnt_t'(alert_pulses - start_alerts), 16'd1);
  endtask

  task automatic test_fail_count();
    int exp_fails;
    cnt_t exp_max;
    exp_fails = 0;
    wb_write(`ENT_REG_STATUS, 32'h0);
    repeat (3) begin
      clear_hist();
      send_fail_window(symbol_t'($random(seed)));
      wait_alert();
      exp_max = hist_max();
      if (exp_max > 10) exp_fails = exp_fails + 1;
    end
    wb_read(`ENT_REG_STATUS, rd);
    check_cnt("STATUS.fail_cnt", cnt_t'(rd[FailLsb +: 8]), cnt_t'(exp_fails));
    check_bit("STATUS.fail", rd[FailBit], 1'b1);
    // Any write clears the count and sticky bits, the maximum stays
    wb_write(`ENT_REG_STATUS, 32'hFFFF_FFFF);
    wb_read(`ENT_REG_STATUS, rd);
    check_data("STATUS", rd, {16'h0, exp_max});
  endtask

  task automatic test_clear_and_disable();
    int start_alerts;
    wb_write(`ENT_REG_THRESH, 32'h0000_FFFF);
    wb_write(`ENT_REG_WINDOW, 32'd32);
    wb_write(`ENT_REG_CTRL, 32'h1);
    // Partial window thrown away by the clear
    send_random(10);
    wb_write(`ENT_REG_CTRL, 32'h3);
    clear_hist();
    send_random(32);
    last_max = hist_max();
    wb_read(`ENT_REG_STATUS, rd);
    check_cnt("STATUS.max after clear", rd[15:0], last_max);
    // Disabled, more than a window of symbols and no wrap
    wb_write(`ENT_REG_CTRL, 32'h0);
    // Zero threshold, any wrap while disabled would raise alert_o
    wb_write(`ENT_REG_THRESH, 32'h0);
    start_alerts = alert_pulses;
    send_random(40);
    wb_read(`ENT_REG_STATUS, rd);
    check_cnt("STATUS.max while disabled", rd[15:0], last_max);
    check_cnt("alert_o pulses", cnt_t'(alert_pulses - start_alerts), '0);
    wb_write(`ENT_REG_THRESH, 32'h0000_FFFF);
    wb_write(`ENT_REG_CTRL, 32'h1);
    clear_hist();
    send_random(32);
    wb_read(`ENT_REG_STATUS, rd);
    check_cnt("STATUS.max after enable", rd[15:0], hist_max());
    check_bit("STATUS.count_err", rd[ErrBit], 1'b0);
    check_bit("count_err_o", count_err_o, 1'b0);
  endtask

  initial begin
    reset_i      <= 1'b1;
    wb_cyc_i     <= 1'b0;
    wb_stb_i     <= 1'b0;
    wb_we_i      <= 1'b0;
    wb_adr_i     <= '0;
    wb_dat_i     <= '0;
    rng_symbol_i <= '0;
    rng_valid_i  <= 1'b0;
    seed     = 32'h58d3;
    errors   = 0;
    timeouts = 0;
    last_max = '0;
    clear_hist();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;

    test_reset_values();
    test_random_windows();
    test_single_symbol_fail();
    test_fail_count();
    test_clear_and_disable();

    repeat (4) @(posedge clk_i);
    errors = errors + monitor_errors;
    $display("errors=%0d timeouts=%0d alert_pulses=%0d", errors, timeouts, alert_pulses);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* include/ent_ht_params.svh */
`ifndef ENT_HT_PARAMS_SVH
`define ENT_HT_PARAMS_SVH

// Raw noise symbol width and the number of histogram bins it selects
`define ENT_SYMBOL_WIDTH 4
`define ENT_NUM_BINS 16

// Bin counters, threshold, window size and window maximum
`define ENT_CNT_WIDTH 16

// Saturating count of failed windows
`define ENT_FAIL_CNT_WIDTH 8

// Wishbone bus widths
`define ENT_WB_ADDR_WIDTH 4
`define ENT_WB_DATA_WIDTH 32

// Register byte offsets
`define ENT_REG_CTRL 4'h0
`define ENT_REG_THRESH 4'h4
`define ENT_REG_WINDOW 4'h8
`define ENT_REG_STATUS 4'hC

`endif

/* run.sh */
#!/bin/sh
# Build the entropy health monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module ent_ht_tb -f sources.f -o ent_ht_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/ent_ht_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Result: PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* source/ent_bucket_ht.sv */
`timescale 1ns/1ps
`include "ent_ht_params.svh"

module ent_bucket_ht (
  input  logic                clk_i,
  input  logic                reset_i,
  input  ent_ht_pkg::symbol_t rng_symbol_i,
  input  logic                rng_valid_i,
  input  logic                wrap_i,
  ht_cfg_if.core              cfg,
  ht_result_if.core           res
);
  import ent_ht_pkg::*;

  logic [`ENT_NUM_BINS-1:0] bin_incr;
  logic [`ENT_NUM_BINS-1:0] bin_over;
  logic [`ENT_NUM_BINS-1:0] bin_err;
  cnt_t [`ENT_NUM_BINS-1:0] bin_cnt;
  cnt_t                     bin_max;
  logic                     bin_clr;
  logic                     count_en;

  // Symbols only count while running and not being cleared
  assign count_en = rng_valid_i && cfg.active && !cfg.clear;

  // Window end reloads the bins, clear or disable empties them
  assign bin_clr = wrap_i || cfg.clear || !cfg.active;

  for (genvar i = 0; i < `ENT_NUM_BINS; i++) begin : gen_bin
    // One-hot decode of the symbol into its bin
    assign bin_incr[i] = count_en && (rng_symbol_i == symbol_t'(i));

    ent_redun_count u_ent_redun_count (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .clr_i   (bin_clr),
      .incr_i  (bin_incr[i]),
      .cnt_o   (bin_cnt[i]),
      .err_o   (bin_err[i])
    );

    // Per-bin threshold compare
    assign bin_over[i] = (bin_cnt[i] > cfg.thresh);
  end : gen_bin

  // Largest bin of the current window
  ent_max_tree u_ent_max_tree (
    .values_i (bin_cnt),
    .max_o    (bin_max)
  );

  // Results are read by the register block in the wrap cycle
  assign res.wrap      = wrap_i;
  assign res.test_cnt  = bin_max;
  // One-cycle failure pulse, only at a window end
  assign res.fail      = cfg.active && wrap_i && (|bin_over);
  assign res.count_err = |bin_err;

endmodule

/* source/ent_ht_if.sv */
`timescale 1ns/1ps

// Configuration from the register block to the test core
interface ht_cfg_if;
  import ent_ht_pkg::*;

  // CTRL bit 0
  logic active;
  // One-cycle pulse from a CTRL bit 1 write
  logic clear;
  cnt_t thresh;
  cnt_t window_size;

  modport regs (output active, output clear, output thresh, output window_size);
  modport core (input active, input clear, input thresh, input window_size);

endinterface

// Per-window results from the test core to the register block
interface ht_result_if;
  import ent_ht_pkg::*;

  // Window wrap pulse, passed through from the window controller
  logic wrap;
  // Largest bin count, meaningful in the wrap cycle
  cnt_t test_cnt;
  // Threshold failure, only in the wrap cycle
  logic fail;
  // Any redundant counter pair disagrees
  logic count_err;

  modport core (output wrap, output test_cnt, output fail, output count_err);
  modport regs (input wrap, input test_cnt, input fail, input count_err);

endinterface

/* source/ent_ht_pkg.sv */
`include "ent_ht_params.svh"

package ent_ht_pkg;

  // One raw noise symbol, also the bin index
  typedef logic [`ENT_SYMBOL_WIDTH-1:0] symbol_t;

  // Bin count, threshold, window size or window maximum
  typedef logic [`ENT_CNT_WIDTH-1:0] cnt_t;

  // Number of failed windows, saturates at all ones
  typedef logic [`ENT_FAIL_CNT_WIDTH-1:0] fail_cnt_t;

  // Wishbone byte address
  typedef logic [`ENT_WB_ADDR_WIDTH-1:0] wb_addr_t;

  // Wishbone data word
  typedef logic [`ENT_WB_DATA_WIDTH-1:0] wb_data_t;

endpackage

/* source/ent_ht_top.sv */
`timescale 1ns/1ps

module ent_ht_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  ent_ht_pkg::wb_addr_t wb_adr_i,
  input  ent_ht_pkg::wb_data_t wb_dat_i,
  output ent_ht_pkg::wb_data_t wb_dat_o,
  output logic                 wb_ack_o,
  input  ent_ht_pkg::symbol_t  rng_symbol_i,
  input  logic                 rng_valid_i,
  output logic                 alert_o,
  output logic                 count_err_o
);

  // Window end pulse, window controller to bucket test
  logic window_wrap;

  ht_cfg_if    u_cfg_if ();
  ht_result_if u_res_if ();

  // Register slave, configuration out and results in
  ent_ht_wb_regs u_ent_ht_wb_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg      (u_cfg_if.regs),
    .res      (u_res_if.regs)
  );

  ent_window_ctrl u_ent_window_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rng_valid_i (rng_valid_i),
    .cfg         (u_cfg_if.core),
    .wrap_o      (window_wrap)
  );

  ent_bucket_ht u_ent_bucket_ht (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rng_symbol_i (rng_symbol_i),
    .rng_valid_i  (rng_valid_i),
    .wrap_i       (window_wrap),
    .cfg          (u_cfg_if.core),
    .res          (u_res_if.core)
  );

  // Alerts straight from the core, fail is already a one-cycle pulse
  assign alert_o     = u_res_if.fail;
  assign count_err_o = u_res_if.count_err;

endmodule

/* source/ent_ht_wb_regs.sv */
`timescale 1ns/1ps
`include "ent_ht_params.svh"

module ent_ht_wb_regs (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  ent_ht_pkg::wb_addr_t wb_adr_i,
  input  ent_ht_pkg::wb_data_t wb_dat_i,
  output ent_ht_pkg::wb_data_t wb_dat_o,
  output logic                 wb_ack_o,
  ht_cfg_if.regs               cfg,
  ht_result_if.regs            res
);
  import ent_ht_pkg::*;

  // Default window length after reset
  localparam cnt_t WindowReset = cnt_t'(64);

  // STATUS field positions
  localparam int StatFailCntLsb = `ENT_CNT_WIDTH;
  localparam int StatErrBit     = `ENT_CNT_WIDTH + `ENT_FAIL_CNT_WIDTH;
  localparam int StatFailBit    = StatErrBit + 1;

  logic      ack_q;
  wb_data_t  dat_q;
  wb_data_t  rd_data;
  logic      req;
  logic      wr_en;

  logic      active_q;
  logic      clear_q;
  cnt_t      thresh_q;
  cnt_t      window_q;
  cnt_t      max_q;
  fail_cnt_t fail_cnt_q;
  logic      sticky_err_q;
  logic      sticky_fail_q;

  // New request, the ack-cycle strobe is not seen again
  assign req   = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr_en = req && wb_we_i;

  // Read mux, unused bits read as zero
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      `ENT_REG_CTRL: rd_data[0] = active_q;
      `ENT_REG_THRESH: rd_data[`ENT_CNT_WIDTH-1:0] = thresh_q;
      `ENT_REG_WINDOW: rd_data[`ENT_CNT_WIDTH-1:0] = window_q;
      `ENT_REG_STATUS: begin
        rd_data[`ENT_CNT_WIDTH-1:0]                   = max_q;
        rd_data[StatFailCntLsb +: `ENT_FAIL_CNT_WIDTH] = fail_cnt_q;
        rd_data[StatErrBit]                           = sticky_err_q;
        rd_data[StatFailBit]                          = sticky_fail_q;
      end
      default: rd_data = '0;
    endcase
  end

  // Bus handshake, one ack per request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Read data sampled with the request, valid alongside ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  // Control registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      clear_q  <= 1'b0;
      thresh_q <= '0;
      window_q <= WindowReset;
    end else begin
      // Clear is self-clearing
      clear_q <= 1'b0;
      if (wr_en) begin
        case (wb_adr_i)
          `ENT_REG_CTRL: begin
            active_q <= wb_dat_i[0];
            clear_q  <= wb_dat_i[1];
          end
          `ENT_REG_THRESH: thresh_q <= wb_dat_i[`ENT_CNT_WIDTH-1:0];
          `ENT_REG_WINDOW: window_q <= wb_dat_i[`ENT_CNT_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // Status, updated at the end of each wrap cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      max_q         <= '0;
      fail_cnt_q    <= '0;
      sticky_err_q  <= 1'b0;
      sticky_fail_q <= 1'b0;
    end else begin
      if (res.wrap) begin
        max_q <= res.test_cnt;
      end
      if (res.fail) begin
        sticky_fail_q <= 1'b1;
        // Hold at the top instead of rolling over
        if (fail_cnt_q != '1) begin
          fail_cnt_q <= fail_cnt_q + 1'b1;
        end
      end
      if (res.count_err) begin
        sticky_err_q <= 1'b1;
      end
      // Any STATUS write wins over a same-cycle update
      if (wr_en && (wb_adr_i == `ENT_REG_STATUS)) begin
        fail_cnt_q    <= '0;
        sticky_err_q  <= 1'b0;
        sticky_fail_q <= 1'b0;
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

  assign cfg.active      = active_q;
  assign cfg.clear       = clear_q;
  assign cfg.thresh      = thresh_q;
  assign cfg.window_size = window_q;

endmodule

/* source/ent_max_tree.sv */
`timescale 1ns/1ps
`include "ent_ht_params.svh"

module ent_max_tree (
  input  ent_ht_pkg::cnt_t [`ENT_NUM_BINS-1:0] values_i,
  output ent_ht_pkg::cnt_t                     max_o
);
  import ent_ht_pkg::*;

  localparam int NumLeaves = `ENT_NUM_BINS;
  localparam int NumLevels = $clog2(NumLeaves);
  localparam int NumNodes  = 2 * NumLeaves - 1;

  // Heap-ordered tree, node 0 is the root
  // Children of node n sit at 2n+1 and 2n+2
  cnt_t node [NumNodes];

  // Leaves fill the last level
  for (genvar i = 0; i < NumLeaves; i++) begin : gen_leaf
    assign node[NumLeaves - 1 + i] = values_i[i];
  end : gen_leaf

  // Pairwise compare, one level of the tree at a time
  for (genvar lvl = 0; lvl < NumLevels; lvl++) begin : gen_level
    for (genvar k = 0; k < (1 << lvl); k++) begin : gen_node
      localparam int Idx = (1 << lvl) - 1 + k;
      localparam int Lft = 2 * Idx + 1;
      localparam int Rgt = 2 * Idx + 2;

      // Ties pick the left child, the value is the same either way
      assign node[Idx] = (node[Rgt] > node[Lft]) ? node[Rgt] : node[Lft];
    end : gen_node
  end : gen_level

  assign max_o = node[0];

endmodule

/* source/ent_redun_count.sv */
`timescale 1ns/1ps

module ent_redun_count (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             clr_i,
  input  logic             incr_i,
  output ent_ht_pkg::cnt_t cnt_o,
  output logic             err_o
);
  import ent_ht_pkg::*;

  // Primary copy counts up from zero
  cnt_t up_q;
  // Shadow copy counts down from all ones
  cnt_t dn_q;
  logic at_max;
  cnt_t copy_sum;

  // Stop at the top so the copies never wrap
  assign at_max = (up_q == '1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      up_q <= '0;
      dn_q <= '1;
    end else if (clr_i) begin
      // Reload, keeping a same-cycle increment
      if (incr_i) begin
        up_q <= cnt_t'(1);
        dn_q <= ~cnt_t'(1);
      end else begin
        up_q <= '0;
        dn_q <= '1;
      end
    end else if (incr_i && !at_max) begin
      up_q <= up_q + 1'b1;
      dn_q <= dn_q - 1'b1;
    end
  end

  // Copies always sum to all ones when healthy
  assign copy_sum = up_q + dn_q;
  assign err_o    = (copy_sum != '1);

  assign cnt_o = up_q;

endmodule

/* source/ent_window_ctrl.sv */
`timescale 1ns/1ps

module ent_window_ctrl (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     rng_valid_i,
  ht_cfg_if.core   cfg,
  output logic     wrap_o
);
  import ent_ht_pkg::*;

  // Symbols accepted so far in this window
  cnt_t win_cnt_q;
  cnt_t cnt_inc;
  logic wrap_q;

  assign cnt_inc = win_cnt_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      win_cnt_q <= '0;
      wrap_q    <= 1'b0;
    end else if (!cfg.active || cfg.clear) begin
      // Idle or cleared, drop the partial window
      win_cnt_q <= '0;
      wrap_q    <= 1'b0;
    end else begin
      wrap_q <= 1'b0;
      if (rng_valid_i) begin
        if (cnt_inc == cfg.window_size) begin
          // Last symbol of the window, restart now
          // A symbol in the wrap cycle becomes the first of the next window
          win_cnt_q <= '0;
          wrap_q    <= 1'b1;
        end else begin
          win_cnt_q <= cnt_inc;
        end
      end
    end
  end

  assign wrap_o = wrap_q;

endmodule

/* sources.f */
+incdir+include
source/ent_ht_pkg.sv
source/ent_ht_if.sv
source/ent_redun_count.sv
source/ent_max_tree.sv
source/ent_window_ctrl.sv
source/ent_bucket_ht.sv
source/ent_ht_wb_regs.sv
source/ent_ht_top.sv
dv/ent_ht_tb.sv
